// ==== rtl/fetch_consts.svh ====
/*
 * Sizing constants for the fetch front end.
 * IMEM_WORDS, BP_ENTRIES and FQ_DEPTH must be powers of two.
 * The memory must be smaller than the byte address space.
 */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Datapath widths
`define FETCH_ADDR_W 16 // Byte address / PC bits
`define FETCH_INST_W 16 // One instruction word

// Storage depths
`define IMEM_WORDS   256 // Indexed by pc[8:1]
`define BP_ENTRIES   16  // Indexed by pc[4:1]
`define FQ_DEPTH     4   // Fetch queue slots

`endif

// ==== rtl/fetch_pkg.sv ====
/*
 * Shared types of the fetch front end.
 * Widths come from fetch_consts.svh.
 */
`include "fetch_consts.svh"

package fetch_pkg;

  typedef logic [`FETCH_ADDR_W-1:0] addr_t; // PC or byte address
  typedef logic [`FETCH_INST_W-1:0] inst_t; // Instruction word
  typedef logic [1:0]               ctr_t;  // 2-bit saturating counter, msb = taken

  // Table index types, derived from the depths
  typedef logic [$clog2(`IMEM_WORDS)-1:0] imem_idx_t;
  typedef logic [$clog2(`BP_ENTRIES)-1:0] bp_idx_t;
  typedef logic [$clog2(`FQ_DEPTH)-1:0]   fq_ptr_t;
  typedef logic [$clog2(`FQ_DEPTH+1)-1:0] fq_cnt_t; // Holds 0..FQ_DEPTH

  // APB read wait state
  typedef enum logic {
    apb_idle,
    apb_wait
  } apb_state_t;

  // One fetch queue slot
  typedef struct packed {
    addr_t pc;
    inst_t inst;
    ctr_t  ctr;
    addr_t target;
  } fq_entry_t;

endpackage

// ==== rtl/fetch_if.sv ====
/*
 * Links inside the fetch front end.
 * fetch_q_if is valid/ready; bp_lookup_if is answered in the same cycle.
 */

// PC stage to fetch queue
interface fetch_q_if;
  logic             valid;  // Entry offered
  logic             ready;  // Queue not full
  fetch_pkg::addr_t pc;
  fetch_pkg::inst_t inst;
  fetch_pkg::ctr_t  ctr;    // Counter seen at lookup
  fetch_pkg::addr_t target; // Predicted target

  modport source (output valid, pc, inst, ctr, target, input ready);
  modport sink   (input valid, pc, inst, ctr, target, output ready);
endinterface

// PC stage to branch predictor
interface bp_lookup_if;
  fetch_pkg::addr_t lookup_pc;
  logic             taken;  // Counter msb and valid BTB entry
  fetch_pkg::ctr_t  ctr;
  fetch_pkg::addr_t target;

  modport fetch     (output lookup_pc, input taken, ctr, target);
  modport predictor (input lookup_pc, output taken, ctr, target);
endinterface

// ==== rtl/imem_apb.sv ====
/*
 * Instruction memory, loaded and read back over APB.
 * Writes finish in the first access cycle, reads add one wait state.
 * Out of range accesses flag pslverr and writes to them are dropped.
 */
`include "fetch_consts.svh"

module imem_apb (
  input  logic             clk,
  input  logic             rst,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  fetch_pkg::addr_t paddr,
  input  fetch_pkg::inst_t pwdata,
  output fetch_pkg::inst_t prdata,
  output logic             pready,
  output logic             pslverr,
  input  fetch_pkg::addr_t fetch_pc,
  output fetch_pkg::inst_t fetch_inst
);

  localparam int IDX_W = $bits(fetch_pkg::imem_idx_t);

  fetch_pkg::inst_t      mem [`IMEM_WORDS]; // Word array
  fetch_pkg::apb_state_t state;
  fetch_pkg::imem_idx_t  apb_idx;
  logic                  access;            // APB access phase
  logic                  bad_addr;          // Past end of memory

  assign access   = psel & penable;
  assign apb_idx  = paddr[IDX_W:1]; // Word aligned, bit 0 ignored
  assign bad_addr = |paddr[`FETCH_ADDR_W-1:IDX_W+1];

  //////////////////////
  // APB handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fetch_pkg::apb_idle;
    end else begin
      case (state)
        fetch_pkg::apb_idle: if (access && !pwrite) state <= fetch_pkg::apb_wait;
        default:             state <= fetch_pkg::apb_idle; // Data returned
      endcase
    end
  end

  assign pready  = access & (pwrite | (state == fetch_pkg::apb_wait));
  assign pslverr = pready & bad_addr;

  //////////////////////
  // Storage
  always_ff @(posedge clk) begin
    if (access && pwrite && !bad_addr) mem[apb_idx] <= pwdata;
    // Read data latched in the first access cycle
    if (access && !pwrite && state == fetch_pkg::apb_idle)
      prdata <= bad_addr ? '0 : mem[apb_idx];
  end

  assign fetch_inst = mem[fetch_pc[IDX_W:1]]; // Combinational fetch port

endmodule

// ==== rtl/branch_predictor.sv ====
/*
 * 2-bit counter table plus direct mapped BTB, same index from pc[4:1].
 * Lookup is combinational; an update is seen one cycle later.
 * No tags, so aliasing PCs share an entry.
 */
`include "fetch_consts.svh"

module branch_predictor (
  input  logic                clk,
  input  logic                rst,
  bp_lookup_if.predictor      lookup,
  input  logic                res_valid,  // Resolution strobe
  input  fetch_pkg::addr_t    res_pc,
  input  logic                res_taken,
  input  fetch_pkg::addr_t    res_target,
  input  fetch_pkg::ctr_t     res_ctr     // Counter that travelled with the entry
);

  localparam int IDX_W = $bits(fetch_pkg::bp_idx_t);

  fetch_pkg::ctr_t        ctr_tbl [`BP_ENTRIES];
  fetch_pkg::addr_t       tgt_tbl [`BP_ENTRIES]; // BTB targets
  logic [`BP_ENTRIES-1:0] tgt_vld;                // BTB valid bits
  fetch_pkg::bp_idx_t     lk_idx;
  fetch_pkg::bp_idx_t     res_idx;
  fetch_pkg::ctr_t        ctr_next;               // Stepped counter

  assign lk_idx  = lookup.lookup_pc[IDX_W:1];
  assign res_idx = res_pc[IDX_W:1];

  //////////////////////
  // Lookup
  assign lookup.ctr    = ctr_tbl[lk_idx];
  assign lookup.target = tgt_tbl[lk_idx];
  assign lookup.taken  = ctr_tbl[lk_idx][1] & tgt_vld[lk_idx]; // Need a target to jump

  //////////////////////
  // Update
  // Step toward the outcome, saturate at 00 and 11
  always_comb begin
    if (res_taken)
      ctr_next = (res_ctr == 2'b11) ? res_ctr : res_ctr + 2'b01;
    else
      ctr_next = (res_ctr == 2'b00) ? res_ctr : res_ctr - 2'b01;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `BP_ENTRIES; i++) begin
        ctr_tbl[i] <= 2'b01; // Weakly not taken
      end
      tgt_vld <= '0;
    end else if (res_valid) begin
      ctr_tbl[res_idx] <= ctr_next;
      if (res_taken) tgt_vld[res_idx] <= 1'b1;
    end
  end

  // Target payload, qualified by tgt_vld
  always_ff @(posedge clk) begin
    if (res_valid && res_taken) tgt_tbl[res_idx] <= res_target;
  end

endmodule

// ==== rtl/fetch_pc.sv ====
/*
 * PC register and next PC select: redirect, predicted target, PC+2.
 * One entry per cycle while run is high; back-pressure holds the PC.
 */

module fetch_pc (
  input  logic             clk,
  input  logic             rst,
  input  logic             run,          // Fetch allowed
  input  logic             redirect,     // From back end
  input  fetch_pkg::addr_t redirect_pc,
  output fetch_pkg::addr_t imem_addr,
  input  fetch_pkg::inst_t imem_inst,
  bp_lookup_if.fetch       bp,
  fetch_q_if.source        fq
);

  fetch_pkg::addr_t pc;
  fetch_pkg::addr_t pc_seq;  // Fall through
  fetch_pkg::addr_t pc_next;
  logic             push;    // Entry accepted this edge

  //////////////////////
  // Current PC out
  assign imem_addr    = pc;
  assign bp.lookup_pc = pc;

  // Entry for the queue, all read at the current PC
  assign fq.valid  = run & ~redirect; // Nothing pushed on a redirect edge
  assign fq.pc     = pc;
  assign fq.inst   = imem_inst;
  assign fq.ctr    = bp.ctr;
  assign fq.target = bp.target;

  assign push = fq.valid & fq.ready;

  //////////////////////
  // Next PC
  assign pc_seq = pc + fetch_pkg::addr_t'(2);

  always_comb begin
    if (redirect)
      pc_next = redirect_pc;
    else if (bp.taken)
      pc_next = bp.target;
    else
      pc_next = pc_seq;
  end

  always_ff @(posedge clk) begin
    if (rst)
      pc <= '0;
    else if (redirect || push) // Otherwise hold, stalled or idle
      pc <= pc_next;
  end

endmodule

// ==== rtl/fetch_queue.sv ====
/*
 * Circular FIFO of fetch entries, FQ_DEPTH a power of two.
 * Push and pop may share a cycle. Flush empties it and drops any push.
 * Head is visible on out_* while out_valid is high.
 */
`include "fetch_consts.svh"

module fetch_queue (
  input  logic             clk,
  input  logic             rst,
  input  logic             flush,     // Redirect
  fetch_q_if.sink          fq,
  output logic             out_valid,
  input  logic             out_ready,
  output fetch_pkg::addr_t out_pc,
  output fetch_pkg::inst_t out_inst,
  output fetch_pkg::ctr_t  out_ctr,
  output fetch_pkg::addr_t out_target
);

  fetch_pkg::fq_entry_t slots [`FQ_DEPTH];
  fetch_pkg::fq_ptr_t   wptr;
  fetch_pkg::fq_ptr_t   rptr;
  fetch_pkg::fq_cnt_t   count;
  logic                 push;
  logic                 pop;

  assign fq.ready  = (count != fetch_pkg::fq_cnt_t'(`FQ_DEPTH)); // Not full
  assign out_valid = (count != '0);

  assign push = fq.valid & fq.ready;
  assign pop  = out_valid & out_ready;

  //////////////////////
  // Pointers and count
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) wptr <= wptr + 1'b1; // Wraps at depth
      if (pop)  rptr <= rptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;     // Both or neither
      endcase
    end
  end

  // Slot payload
  always_ff @(posedge clk) begin
    if (push && !flush)
      slots[wptr] <= '{pc: fq.pc, inst: fq.inst, ctr: fq.ctr, target: fq.target};
  end

  //////////////////////
  // Head
  assign out_pc     = slots[rptr].pc;
  assign out_inst   = slots[rptr].inst;
  assign out_ctr    = slots[rptr].ctr;
  assign out_target = slots[rptr].target;

endmodule

// ==== rtl/fetch_top.sv ====
/*
 * Fetch front end top: memory, predictor, PC stage and queue.
 * Redirect also flushes the queue.
 */

module fetch_top (
  input  logic             clk,
  input  logic             rst,
  // APB slave
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  fetch_pkg::addr_t paddr,
  input  fetch_pkg::inst_t pwdata,
  output fetch_pkg::inst_t prdata,
  output logic             pready,
  output logic             pslverr,
  // Control from back end
  input  logic             run,
  input  logic             redirect,
  input  fetch_pkg::addr_t redirect_pc,
  input  logic             res_valid,
  input  fetch_pkg::addr_t res_pc,
  input  logic             res_taken,
  input  fetch_pkg::addr_t res_target,
  input  fetch_pkg::ctr_t  res_ctr,
  // Decode side
  output logic             out_valid,
  input  logic             out_ready,
  output fetch_pkg::addr_t out_pc,
  output fetch_pkg::inst_t out_inst,
  output fetch_pkg::ctr_t  out_ctr,
  output fetch_pkg::addr_t out_target
);

  fetch_q_if   fq ();  // PC stage to queue
  bp_lookup_if bp ();  // PC stage to predictor

  fetch_pkg::addr_t imem_addr;
  fetch_pkg::inst_t imem_inst;

  imem_apb u_imem (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .fetch_pc   (imem_addr),
    .fetch_inst (imem_inst)
  );

  branch_predictor u_bp (
    .clk, .rst,
    .lookup (bp.predictor),
    .res_valid, .res_pc, .res_taken, .res_target, .res_ctr
  );

  fetch_pc u_pc (
    .clk, .rst, .run, .redirect, .redirect_pc,
    .imem_addr, .imem_inst,
    .bp (bp.fetch),
    .fq (fq.source)
  );

  fetch_queue u_fq (
    .clk, .rst,
    .flush (redirect),
    .fq    (fq.sink),
    .out_valid, .out_ready, .out_pc, .out_inst, .out_ctr, .out_target
  );

endmodule

// ==== verif/tb_fetch.sv ====
/*
 * Testbench for fetch_top covering APB load and readback, sequential fetch,
 * redirect flush and predictor training.
 * Reference model keeps its own image, counter and target tables.
 */
`include "fetch_consts.svh"

module tb_fetch;

  localparam logic [2:0] op_wr    = 3'd0; // APB write a <- b
  localparam logic [2:0] op_rd    = 3'd1; // APB read a, compare with image
  localparam logic [2:0] op_bad   = 3'd2; // Out of range access at a
  localparam logic [2:0] op_run   = 3'd3; // a deliveries, first pc want
  localparam logic [2:0] op_redir = 3'd4; // Redirect to a
  localparam logic [2:0] op_res   = 3'd5; // Resolve pc a to target b, refetch a for counter want
  localparam int         n_steps  = 19;

  logic             clk, rst, psel, penable, pwrite, pready, pslverr;
  logic             run, redirect, res_valid, res_taken, out_valid, out_ready;
  fetch_pkg::addr_t paddr, redirect_pc, res_pc, res_target, out_pc, out_target;
  fetch_pkg::inst_t pwdata, prdata, out_inst;
  fetch_pkg::ctr_t  res_ctr, out_ctr;

  // Reference model
  logic [15:0] img  [`IMEM_WORDS]; // Memory image
  logic [1:0]  mctr [`BP_ENTRIES]; // Counters
  logic [15:0] mtgt [`BP_ENTRIES]; // BTB targets
  logic        mvld [`BP_ENTRIES];
  logic [15:0] mpc;                // Next PC expected at decode
  logic [31:0] rng;

  fetch_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////
  // Helpers
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13); // xorshift32
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Saturating step toward the outcome
  function automatic logic [1:0] step_ctr(input logic [1:0] c, input logic t);
    if (t) return (c == 2'b11) ? c : c + 2'b01;
    return (c == 2'b00) ? c : c - 2'b01;
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic compare_hex(input string name, input logic [15:0] got, input logic [15:0] want);
    assert (got === want)
      else stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, want));
  endtask

  // One APB transfer that counts its access cycles with pready low
  task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
                          output logic [15:0] rdata, output logic err, output int waits);
    @(negedge clk);
    psel    = 1'b1; // Setup phase
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    @(posedge clk); // Slave response as seen at the edge
    while (!pready) begin
      assert (waits < 4) else stop_on_error("Timeout waiting for pready");
      waits++;
      @(posedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Redirect for one edge, which also empties the queue
  task automatic redirect_to(input logic [15:0] pc);
    @(negedge clk);
    redirect    = 1'b1;
    redirect_pc = pc;
    @(negedge clk);
    redirect    = 1'b0;
  endtask

  // Refetch pc with decode stalled and check the head of the queue
  task automatic check_head(input logic [15:0] pc, input logic [15:0] want_ctr);
    int cycles;
    cycles = 0;
    redirect_to(pc);
    run = 1'b1;
    while (!out_valid) begin
      assert (cycles < 10) else stop_on_error("Timeout waiting for out_valid after redirect");
      @(negedge clk);
      cycles++;
    end
    compare_hex("cycles to first entry", 16'(cycles), 16'h1); // Second edge after redirect
    compare_hex("out_pc", out_pc, pc);
    compare_hex("out_ctr", {14'h0, out_ctr}, want_ctr);
    run = 1'b0; // Leftovers go with the next redirect
  endtask

  // Pop n entries under random out_ready and check each against the model
  task automatic deliver(input int n);
    int          got;
    int          cycles;
    logic [31:0] r;
    logic [3:0]  idx;
    got    = 0;
    cycles = 0;
    run    = 1'b1;
    while (got < n) begin
      @(negedge clk);
      r         = next_rand();
      out_ready = r[0] | r[1]; // About 3 in 4 cycles
      if (out_valid && out_ready) begin
        idx = mpc[4:1];
        compare_hex("out_pc", out_pc, mpc);
        compare_hex("out_inst", out_inst, img[mpc[8:1]]);
        compare_hex("out_ctr", {14'h0, out_ctr}, {14'h0, mctr[idx]});
        if (mvld[idx]) compare_hex("out_target", out_target, mtgt[idx]);
        mpc = (mctr[idx][1] && mvld[idx]) ? mtgt[idx] : mpc + 16'd2;
        got++;
      end
      cycles++;
      assert (cycles < 20 * n + 50) else stop_on_error("Timeout waiting for fetch deliveries");
    end
    @(negedge clk);
    run       = 1'b0; // Leftovers stay queued until a redirect
    out_ready = 1'b0;
  endtask

  //////////////////////
  // Step table with fields {op, a, b, flag, want}
  function automatic logic [51:0] step_at(input int i);
    case (i)
      0:  return {op_wr,    16'h0020, 16'h1234, 1'b0, 16'h0};
      1:  return {op_wr,    16'h0022, 16'hbeef, 1'b0, 16'h0};
      2:  return {op_rd,    16'h0020, 16'h0000, 1'b0, 16'h0};
      3:  return {op_rd,    16'h01fe, 16'h0000, 1'b0, 16'h0}; // Last word
      4:  return {op_bad,   16'h0204, 16'hdead, 1'b0, 16'h0}; // Aliases 0x0004
      5:  return {op_bad,   16'hfffe, 16'h5555, 1'b0, 16'h0};
      6:  return {op_run,   16'd40,   16'h0000, 1'b0, 16'h0000};
      7:  return {op_redir, 16'h0100, 16'h0000, 1'b0, 16'h0}; // Stale entries queued
      8:  return {op_run,   16'd8,    16'h0000, 1'b0, 16'h0100};
      9:  return {op_res,   16'h0010, 16'h0040, 1'b1, 16'h2};
      10: return {op_res,   16'h0010, 16'h0040, 1'b1, 16'h3};
      11: return {op_res,   16'h0010, 16'h0040, 1'b1, 16'h3}; // Saturated
      12: return {op_redir, 16'h000c, 16'h0000, 1'b0, 16'h0};
      13: return {op_run,   16'd6,    16'h0000, 1'b0, 16'h000c}; // Jumps 0x10 -> 0x40
      14: return {op_res,   16'h0010, 16'h0040, 1'b0, 16'h2};
      15: return {op_res,   16'h0010, 16'h0040, 1'b0, 16'h1};
      16: return {op_res,   16'h0010, 16'h0040, 1'b0, 16'h0};
      17: return {op_res,   16'h0010, 16'h0040, 1'b0, 16'h0};
      default: return {op_redir, 16'h000c, 16'h0000, 1'b0, 16'h0};
    endcase
  endfunction

  task automatic run_step(input logic [51:0] s);
    logic [2:0]  op;
    logic [15:0] a, b, want, rd;
    logic        flag, err;
    int          waits;
    {op, a, b, flag, want} = s;
    case (op)
      op_wr: begin
        apb_xfer(1'b1, a, b, rd, err, waits);
        compare_hex("pslverr", {15'h0, err}, 16'h0);
        compare_hex("write wait cycles", 16'(waits), 16'h0);
        img[a[8:1]] = b;
      end
      op_rd: begin
        apb_xfer(1'b0, a, 16'h0, rd, err, waits);
        compare_hex("pslverr", {15'h0, err}, 16'h0);
        compare_hex("read wait cycles", 16'(waits), 16'h1);
        compare_hex("prdata", rd, img[a[8:1]]);
      end
      op_bad: begin // Both directions flag and the aliased word stays untouched
        apb_xfer(1'b1, a, b, rd, err, waits);
        compare_hex("pslverr", {15'h0, err}, 16'h1);
        apb_xfer(1'b0, a, 16'h0, rd, err, waits);
        compare_hex("pslverr", {15'h0, err}, 16'h1);
        apb_xfer(1'b0, {7'h0, a[8:0]}, 16'h0, rd, err, waits);
        compare_hex("prdata", rd, img[a[8:1]]);
      end
      op_run: begin
        mpc = want; // First PC expected at decode
        deliver(int'(a));
      end
      op_redir: begin
        redirect_to(a);
      end
      op_res: begin
        @(negedge clk);
        res_valid  = 1'b1;
        res_pc     = a;
        res_target = b;
        res_taken  = flag;
        res_ctr    = mctr[a[4:1]]; // Counter as fetched
        mctr[a[4:1]] = step_ctr(mctr[a[4:1]], flag);
        if (flag) begin
          mtgt[a[4:1]] = b;
          mvld[a[4:1]] = 1'b1;
        end
        @(negedge clk);
        res_valid = 1'b0;
        check_head(a, want);
      end
      default: stop_on_error("Unknown step operation in table");
    endcase
  endtask

  //////////////////////
  // Main sequence
  initial begin
    logic [31:0] word;
    rng = 32'h4016;
    rst = 1'b1;
    {psel, penable, pwrite, run, redirect, res_valid, res_taken, out_ready} = '0;
    {paddr, pwdata, redirect_pc, res_pc, res_target} = '0;
    res_ctr = 2'b00;
    for (int i = 0; i < `BP_ENTRIES; i++) begin
      mctr[i] = 2'b01;
      mvld[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    compare_hex("out_valid", {15'h0, out_valid}, 16'h0);
    compare_hex("pready", {15'h0, pready}, 16'h0);
    compare_hex("pslverr", {15'h0, pslverr}, 16'h0);
    // Random program in every word
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      word = next_rand();
      run_step({op_wr, i[14:0], 1'b0, word[15:0], 1'b0, 16'h0});
    end
    for (int i = 0; i < n_steps; i++) run_step(step_at(i));
    // Final fetch after untraining from the last redirect target 0x000c
    run_step({op_run, 16'd5, 16'h0000, 1'b0, 16'h000c});
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_if.sv
rtl/imem_apb.sv
rtl/branch_predictor.sv
rtl/fetch_pc.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
verif/tb_fetch.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_if.sv
      - rtl/imem_apb.sv
      - rtl/branch_predictor.sv
      - rtl/fetch_pc.sv
      - rtl/fetch_queue.sv
      - rtl/fetch_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_fetch.sv
